// ==== design/bp_pkg.sv ====
package bp_pkg;

	////////////////////
	// Branch kinds and counters

	// Conditional branch kind seen at fetch
	typedef enum logic [2:0]
	{
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU
	} branch_op_e;

	// Two bit saturating counter, top bit means taken
	typedef enum logic [1:0]
	{
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} ctr_e;

	// x1 holds the return address
	localparam logic [4:0] RA_REG = 5'd1;

	// One saturating step up or down
	function automatic ctr_e ctr_step(input ctr_e cur, input logic up);
		ctr_e nxt;
		nxt = cur;
		if (up && (cur != STRONG_T))
			nxt = ctr_e'(cur + 2'd1);
		else if (!up && (cur != STRONG_NT))
			nxt = ctr_e'(cur - 2'd1);
		return nxt;
	endfunction

endpackage

// ==== design/history_predictor.sv ====
`timescale 1ns/10ps

module history_predictor import bp_pkg::*;
#(
	parameter int HIST_WIDTH = 6,
	parameter int PC_BITS    = 4,
	parameter int NUM_HIST   = 1
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pl_stall,
	input  branch_op_e  fetch_op,
	input  logic [31:0] fetch_pc,
	input  logic        train_en,
	input  logic        resolve_taken,
	output ctr_e        ctr
);

	localparam int IDX_WIDTH  = HIST_WIDTH + PC_BITS;
	localparam int TABLE_SIZE = 1 << IDX_WIDTH;
	localparam int SEL_WIDTH  = (NUM_HIST > 1) ? $clog2(NUM_HIST) : 1;

	logic [HIST_WIDTH-1:0] hist [NUM_HIST];
	ctr_e                  ctr_tab [TABLE_SIZE];

	logic [SEL_WIDTH-1:0]  fetch_sel;
	logic [SEL_WIDTH-1:0]  ex_sel;
	logic [IDX_WIDTH-1:0]  fetch_idx;

	logic [IDX_WIDTH-1:0]  idx_id;
	logic [IDX_WIDTH-1:0]  idx_ex;
	branch_op_e            op_id;
	branch_op_e            op_ex;

	// Local mode picks a history register by branch kind
	function automatic logic [SEL_WIDTH-1:0] hist_sel(input branch_op_e op);
		if (NUM_HIST > 1)
			return SEL_WIDTH'(op);
		return '0;
	endfunction

	////////////////////
	// Fetch lookup

	assign fetch_sel = hist_sel(fetch_op);
	assign fetch_idx = {hist[fetch_sel], fetch_pc[PC_BITS+1:2]};
	assign ctr       = ctr_tab[fetch_idx];

	////////////////////
	// id/ex index pipe

	always_ff @(posedge clk)
	begin
		if (!pl_stall)
		begin
			idx_id <= fetch_idx;
			op_id  <= fetch_op;
			idx_ex <= idx_id;
			op_ex  <= op_id;
		end
	end

	assign ex_sel = hist_sel(op_ex);

	////////////////////
	// Training at resolve

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < TABLE_SIZE; i++)
				ctr_tab[i] <= WEAK_NT;
			for (int i = 0; i < NUM_HIST; i++)
				hist[i] <= '0;
		end
		else if (train_en)
		begin
			ctr_tab[idx_ex] <= ctr_step(ctr_tab[idx_ex], resolve_taken);
			// Newest outcome enters at bit 0
			hist[ex_sel]    <= {hist[ex_sel][HIST_WIDTH-2:0], resolve_taken};
		end
	end

	// Training comes from the meta predictor and must respect the stall
	a_no_train_in_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(train_en && pl_stall)
	);

endmodule

// ==== design/meta_predictor.sv ====
`timescale 1ns/10ps

module meta_predictor import bp_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       pl_stall,
	input  logic       pl_flush,
	input  logic       predict_en,
	input  branch_op_e fetch_op,
	input  logic       imm_sign,
	input  ctr_e       global_ctr,
	input  ctr_e       local_ctr,
	input  logic       resolve_en,
	input  logic       resolve_taken,
	output logic       train_en,
	output logic       predict_taken
);

	localparam int NUM_OPS = 8;

	// Choice counters, top bit set selects local
	ctr_e       choice [NUM_OPS];

	logic       use_local;
	ctr_e       sel_ctr;
	logic       sel_strong;

	logic       valid_id;
	logic       valid_ex;
	branch_op_e op_id;
	branch_op_e op_ex;
	logic       g_taken_id;
	logic       g_taken_ex;
	logic       l_taken_id;
	logic       l_taken_ex;
	logic       local_right;

	////////////////////
	// Fetch time choice

	assign use_local  = choice[fetch_op][1];
	assign sel_ctr    = use_local ? local_ctr : global_ctr;
	assign sel_strong = (sel_ctr == STRONG_T) || (sel_ctr == STRONG_NT);

	// Weak states fall back to backward taken
	assign predict_taken = sel_strong ? sel_ctr[1] : imm_sign;

	////////////////////
	// Stage pipe

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_id <= 1'b0;
			valid_ex <= 1'b0;
		end
		else if (!pl_stall)
		begin
			valid_id <= predict_en && (fetch_op != BR_NONE);
			valid_ex <= valid_id && !pl_flush;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!pl_stall)
		begin
			op_id      <= fetch_op;
			g_taken_id <= global_ctr[1];
			l_taken_id <= local_ctr[1];
			op_ex      <= op_id;
			g_taken_ex <= g_taken_id;
			l_taken_ex <= l_taken_id;
		end
	end

	////////////////////
	// Resolve and choice update

	assign train_en    = resolve_en && valid_ex && !pl_stall;
	assign local_right = (l_taken_ex == resolve_taken);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_OPS; i++)
				choice[i] <= WEAK_NT;
		end
		else if (train_en && (g_taken_ex != l_taken_ex))
		begin
			choice[op_ex] <= ctr_step(choice[op_ex], local_right);
		end
	end

	// Counters from both history tables must be settled at fetch
	a_pred_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		predict_en |-> !$isunknown(predict_taken)
	);

endmodule

// ==== design/return_stack.sv ====
`timescale 1ns/10ps

module return_stack import bp_pkg::*;
#(
	parameter int RAS_ADDR_WIDTH = 4
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pl_stall,
	input  logic        pl_flush,
	input  logic        id_jal,
	input  logic        id_jalr,
	input  logic [4:0]  id_rd,
	input  logic [4:0]  id_rs1,
	input  logic [31:0] id_pc_add_4,
	output logic [31:0] jalr_target
);

	localparam int DEPTH = 1 << RAS_ADDR_WIDTH;

	logic [31:0]               stack [DEPTH];
	logic [RAS_ADDR_WIDTH-1:0] sp;
	logic [RAS_ADDR_WIDTH-1:0] sp_inc;
	logic [RAS_ADDR_WIDTH-1:0] sp_dec;
	logic                      op_en;
	logic                      push;
	logic                      pop;

	// Call links ra, return reads ra
	assign push   = (id_jal || id_jalr) && (id_rd == RA_REG);
	assign pop    = id_jalr && (id_rs1 == RA_REG);
	assign op_en  = !pl_stall && !pl_flush;

	// Pointer wraps, oldest entries get overwritten
	assign sp_inc = sp + 1'b1;
	assign sp_dec = sp - 1'b1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sp          <= '0;
			jalr_target <= '0;
			for (int i = 0; i < DEPTH; i++)
				stack[i] <= '0;
		end
		else if (op_en)
		begin
			case ({push, pop})
				2'b10:
				begin
					stack[sp_inc] <= id_pc_add_4;
					sp            <= sp_inc;
					jalr_target   <= id_pc_add_4;
				end
				2'b01:
				begin
					sp          <= sp_dec;
					jalr_target <= stack[sp_dec];
				end
				// Return then call in one go, top is swapped
				2'b11:
				begin
					stack[sp]   <= id_pc_add_4;
					jalr_target <= id_pc_add_4;
				end
				default:
				begin
				end
			endcase
		end
	end

	a_sp_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(pl_stall || pl_flush) |=> $stable(sp)
	);

endmodule

// ==== design/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor import bp_pkg::*;
#(
	parameter int GHR_WIDTH      = 6,
	parameter int GPC_BITS       = 4,
	parameter int LHR_WIDTH      = 5,
	parameter int LPC_BITS       = 3,
	parameter int RAS_ADDR_WIDTH = 4
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pl_stall,
	input  logic        pl_flush,
	input  logic        predict_en,
	input  branch_op_e  fetch_op,
	input  logic [31:0] fetch_pc,
	input  logic        imm_sign,
	input  logic        resolve_en,
	input  logic        resolve_taken,
	input  logic        id_jal,
	input  logic        id_jalr,
	input  logic [4:0]  id_rd,
	input  logic [4:0]  id_rs1,
	input  logic [31:0] id_pc_add_4,
	output logic        predict_taken,
	output logic [31:0] jalr_target
);

	ctr_e global_ctr;
	ctr_e local_ctr;
	logic train_en;

	////////////////////
	// Conditional branches

	// Single shared history
	history_predictor #(
		.HIST_WIDTH (GHR_WIDTH),
		.PC_BITS    (GPC_BITS),
		.NUM_HIST   (1)
	) global_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.pl_stall      (pl_stall),
		.fetch_op      (fetch_op),
		.fetch_pc      (fetch_pc),
		.train_en      (train_en),
		.resolve_taken (resolve_taken),
		.ctr           (global_ctr)
	);

	// One history per branch kind
	history_predictor #(
		.HIST_WIDTH (LHR_WIDTH),
		.PC_BITS    (LPC_BITS),
		.NUM_HIST   (8)
	) local_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.pl_stall      (pl_stall),
		.fetch_op      (fetch_op),
		.fetch_pc      (fetch_pc),
		.train_en      (train_en),
		.resolve_taken (resolve_taken),
		.ctr           (local_ctr)
	);

	meta_predictor meta_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.pl_stall      (pl_stall),
		.pl_flush      (pl_flush),
		.predict_en    (predict_en),
		.fetch_op      (fetch_op),
		.imm_sign      (imm_sign),
		.global_ctr    (global_ctr),
		.local_ctr     (local_ctr),
		.resolve_en    (resolve_en),
		.resolve_taken (resolve_taken),
		.train_en      (train_en),
		.predict_taken (predict_taken)
	);

	////////////////////
	// Returns

	return_stack #(
		.RAS_ADDR_WIDTH (RAS_ADDR_WIDTH)
	) ras_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.pl_stall    (pl_stall),
		.pl_flush    (pl_flush),
		.id_jal      (id_jal),
		.id_jalr     (id_jalr),
		.id_rd       (id_rd),
		.id_rs1      (id_rs1),
		.id_pc_add_4 (id_pc_add_4),
		.jalr_target (jalr_target)
	);

endmodule

// ==== tb/tb_branch_predictor.sv ====
`timescale 1ns/10ps

module tb_branch_predictor import bp_pkg::*;
();

	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int TRAIN_CYCLES   = 20;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        pl_stall;
	logic        pl_flush;
	logic        predict_en;
	branch_op_e  fetch_op;
	logic [31:0] fetch_pc;
	logic        imm_sign;
	logic        resolve_en;
	logic        resolve_taken;
	logic        id_jal;
	logic        id_jalr;
	logic [4:0]  id_rd;
	logic [4:0]  id_rs1;
	logic [31:0] id_pc_add_4;
	logic        predict_taken;
	logic [31:0] jalr_target;

	// Stimulus table with one entry per cycle
	logic        t_predict_en [$];
	branch_op_e  t_op [$];
	logic [31:0] t_pc [$];
	logic        t_imm [$];
	logic        t_res_en [$];
	logic        t_res_taken [$];
	logic        t_stall [$];
	logic        t_flush [$];
	logic        t_jal [$];
	logic        t_jalr [$];
	logic [4:0]  t_rd [$];
	logic [4:0]  t_rs1 [$];
	logic [31:0] t_link [$];
	logic        t_chk_taken [$];
	logic        t_exp_taken [$];
	logic        t_chk_target [$];
	logic [31:0] t_exp_target [$];

	logic [31:0] lcg_state;
	int          taken_errors;
	int          target_errors;
	int          timeouts;

	branch_predictor branch_predictor_inst (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////
	// Compare tasks

	task automatic check_taken(input logic got, input logic exp, input string msg);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s predict_taken %b, expected %b", $time, msg, got, exp);
			taken_errors++;
		end
	endtask

	task automatic check_target(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s jalr_target %h, expected %h", $time, msg, got, exp);
			target_errors++;
		end
	endtask

	////////////////////
	// Table building

	task automatic add_step(input logic en, input branch_op_e op, input logic [31:0] pc,
		input logic imm, input logic res_en, input logic res_taken, input logic stall,
		input logic flush, input logic jal, input logic jalr, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [31:0] link, input logic chk_taken,
		input logic exp_taken, input logic chk_target, input logic [31:0] exp_target);
		t_predict_en.push_back(en);
		t_op.push_back(op);
		t_pc.push_back(pc);
		t_imm.push_back(imm);
		t_res_en.push_back(res_en);
		t_res_taken.push_back(res_taken);
		t_stall.push_back(stall);
		t_flush.push_back(flush);
		t_jal.push_back(jal);
		t_jalr.push_back(jalr);
		t_rd.push_back(rd);
		t_rs1.push_back(rs1);
		t_link.push_back(link);
		t_chk_taken.push_back(chk_taken);
		t_exp_taken.push_back(exp_taken);
		t_chk_target.push_back(chk_target);
		t_exp_target.push_back(exp_target);
	endtask

	task automatic add_fetch(input branch_op_e op, input logic [31:0] pc, input logic imm,
		input logic res_en, input logic res_taken, input logic stall, input logic chk,
		input logic exp);
		add_step(1'b1, op, pc, imm, res_en, res_taken, stall, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0,
			32'h0, chk, exp, 1'b0, 32'h0);
	endtask

	task automatic add_decode(input logic jal, input logic jalr, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [31:0] link, input logic stall, input logic flush,
		input logic [31:0] exp);
		add_step(1'b0, BR_NONE, 32'h0, 1'b0, 1'b0, 1'b0, stall, flush, jal, jalr, rd, rs1,
			link, 1'b0, 1'b0, 1'b1, exp);
	endtask

	// Untrained tables fall back to the immediate sign
	task automatic build_reset_checks();
		logic [31:0] pc;
		for (int k = 0; k < 7; k++)
		begin
			pc = next_random();
			add_fetch(branch_op_e'(k), pc, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
			add_fetch(branch_op_e'(k), pc, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
		end
		add_decode(1'b0, 1'b0, 5'd0, 5'd0, 32'h0, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic build_training(input branch_op_e op, input logic [31:0] pc,
		input logic taken, input logic stall);
		for (int i = 0; i < TRAIN_CYCLES; i++)
			add_fetch(op, pc, !taken, 1'b1, taken, stall, 1'b0, 1'b0);
		add_fetch(op, pc, 1'b0, 1'b0, 1'b0, stall, 1'b1, stall ? 1'b0 : taken);
		add_fetch(op, pc, 1'b1, 1'b0, 1'b0, stall, 1'b1, stall ? 1'b1 : taken);
	endtask

	// 18 calls into a 16 entry stack lose the two oldest
	task automatic build_stack();
		logic [31:0] pushed [18];
		logic [31:0] exp;
		exp = 32'h0;
		for (int i = 0; i < 18; i++)
		begin
			pushed[i] = next_random();
			add_decode(1'b1, 1'b0, RA_REG, 5'd0, pushed[i], 1'b0, 1'b0, exp);
			exp = pushed[i];
		end
		for (int k = 1; k < 16; k++)
		begin
			add_decode(1'b0, 1'b1, 5'd0, RA_REG, 32'h0, 1'b0, 1'b0, exp);
			exp = pushed[17-k];
		end
		// Killed or frozen decode ops
		add_decode(1'b1, 1'b0, RA_REG, 5'd0, next_random(), 1'b0, 1'b1, exp);
		add_decode(1'b0, 1'b1, 5'd0, RA_REG, 32'h0, 1'b1, 1'b0, exp);
		add_decode(1'b1, 1'b1, RA_REG, RA_REG, next_random(), 1'b1, 1'b1, exp);
		// Pointer must not have moved
		add_decode(1'b0, 1'b1, 5'd0, RA_REG, 32'h0, 1'b0, 1'b0, exp);
		exp = pushed[17];
		add_decode(1'b0, 1'b0, 5'd0, 5'd0, 32'h0, 1'b0, 1'b0, exp);
	endtask

	////////////////////
	// Drive and sample

	task automatic drive_idle();
		pl_stall      <= 1'b0;
		pl_flush      <= 1'b0;
		predict_en    <= 1'b0;
		fetch_op      <= BR_NONE;
		fetch_pc      <= 32'h0;
		imm_sign      <= 1'b0;
		resolve_en    <= 1'b0;
		resolve_taken <= 1'b0;
		id_jal        <= 1'b0;
		id_jalr       <= 1'b0;
		id_rd         <= 5'd0;
		id_rs1        <= 5'd0;
		id_pc_add_4   <= 32'h0;
	endtask

	task automatic do_reset();
		int cycles;
		@(posedge clk);
		rst_n <= 1'b0;
		drive_idle();
		cycles = 0;
		while (cycles < RESET_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		rst_n <= 1'b1;
		@(negedge clk);
		cycles = 0;
		while (((jalr_target !== 32'h0) || $isunknown(predict_taken)) &&
			(cycles < TIMEOUT_CYCLES))
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: DUT outputs did not settle after reset");
			timeouts++;
		end
	endtask

	task automatic apply_table();
		int step;
		int cycles;
		step = 0;
		cycles = 0;
		while ((step < t_op.size()) && (cycles < TIMEOUT_CYCLES))
		begin
			@(posedge clk);
			predict_en    <= t_predict_en[step];
			fetch_op      <= t_op[step];
			fetch_pc      <= t_pc[step];
			imm_sign      <= t_imm[step];
			resolve_en    <= t_res_en[step];
			resolve_taken <= t_res_taken[step];
			pl_stall      <= t_stall[step];
			pl_flush      <= t_flush[step];
			id_jal        <= t_jal[step];
			id_jalr       <= t_jalr[step];
			id_rd         <= t_rd[step];
			id_rs1        <= t_rs1[step];
			id_pc_add_4   <= t_link[step];
			@(negedge clk);
			if (t_chk_taken[step])
				check_taken(predict_taken, t_exp_taken[step], $sformatf("step %0d", step));
			if (t_chk_target[step])
				check_target(jalr_target, t_exp_target[step], $sformatf("step %0d", step));
			step++;
			cycles++;
		end
		if (step < t_op.size())
		begin
			$display("Timeout: table stopped at step %0d of %0d", step, t_op.size());
			timeouts++;
		end
		t_predict_en.delete();
		t_op.delete();
		t_pc.delete();
		t_imm.delete();
		t_res_en.delete();
		t_res_taken.delete();
		t_stall.delete();
		t_flush.delete();
		t_jal.delete();
		t_jalr.delete();
		t_rd.delete();
		t_rs1.delete();
		t_link.delete();
		t_chk_taken.delete();
		t_exp_taken.delete();
		t_chk_target.delete();
		t_exp_target.delete();
	endtask

	initial
	begin
		logic [31:0] pc;
		lcg_state     = 32'h1b2;
		taken_errors  = 0;
		target_errors = 0;
		timeouts      = 0;
		rst_n <= 1'b0;
		drive_idle();
		do_reset();

		build_reset_checks();
		build_stack();
		pc = next_random();
		build_training(BR_BNE, pc, 1'b1, 1'b0);
		build_training(BR_BNE, pc, 1'b0, 1'b0);
		apply_table();

		// Fresh tables with training held off by the stall
		do_reset();
		build_training(BR_BLT, next_random(), 1'b1, 1'b1);
		apply_table();

		$display("Errors: %0d predict_taken, %0d jalr_target, %0d timeouts",
			taken_errors, target_errors, timeouts);
		if ((taken_errors == 0) && (target_errors == 0) && (timeouts == 0))
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== sim.f ====
design/bp_pkg.sv
design/history_predictor.sv
design/meta_predictor.sv
design/return_stack.sv
design/branch_predictor.sv
tb/tb_branch_predictor.sv

// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILE_LIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
